// ==== sim.f ====
+incdir+hw
hw/icache_pkg.sv
hw/icache_arrays.sv
hw/icache_victim_sel.sv
hw/icache_fetch_align.sv
hw/icache_ctrl.sv
hw/icache_top.sv
test/icache_assert.sv
test/icache_tb.sv

// ==== Makefile ====
# Verilator build and run of the instruction cache testbench

TOP     := icache_tb
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Testbench passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/icache_tb.sv ====
// Instruction cache testbench
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb
  import icache_pkg::*;
();

  localparam int          CLK_PERIOD  = 8;
  localparam int          NUM_REQ     = 400;
  // Generous bound per fetch with two refills and back-pressure
  localparam int          REQ_CYCLES  = 40;
  localparam logic [31:0] DATA_KEY    = 32'h5a5a_0000;
  localparam int          HIT_LATENCY = 2;

  typedef enum int {
    MEM_IDLE,
    MEM_DELAY,
    MEM_RESP
  } mem_state_e;

  logic       clk_i;
  logic       rst_ni;
  logic       req_valid_i;
  logic       req_ready_o;
  fetch_req_t req_i;
  logic       rsp_valid_o;
  logic       rsp_ready_i;
  fetch_rsp_t rsp_o;
  logic       mem_req_valid_o;
  logic       mem_req_ready_i;
  mem_req_t   mem_req_o;
  logic       mem_rsp_valid_i;
  logic       mem_rsp_ready_o;
  mem_rsp_t   mem_rsp_i;

  integer     seed = 32'h2a1f_0506;
  int         errors;
  int         checks;
  int         cyc;
  int         accepted;
  int         responded;
  int         mem_reqs;
  pc_t        pcs [NUM_REQ];
  // Fetch in flight
  logic       fetch_active;
  pc_t        cur_pc;
  line_addr_t cur_line_a;
  line_addr_t cur_line_b;
  logic       cur_cross;
  logic       cur_known;
  int         accept_cyc;
  logic       rsp_seen;
  // Lines known to be resident and valid ways per set since reset
  line_addr_t known_q [$];
  int         filled [`IC_NUM_SETS];
  // Memory model
  mem_state_e mem_state;
  int         mem_delay;
  line_addr_t mem_line;

  icache_top dut_i (.*);

  bind icache_top icache_assert u_assert (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_ready_o     (req_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_o           (rsp_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_o       (mem_req_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Reference rules
  // ----------------------------------------------------------------------
  // Memory word is its byte address with a fixed key
  function automatic instr_t word_at(pc_t addr);
    return addr ^ DATA_KEY;
  endfunction

  function automatic line_addr_t line_of(pc_t addr);
    return addr[`IC_PLEN-1:`IC_OFFSET_W];
  endfunction

  function automatic set_idx_t set_of(line_addr_t line);
    return line[`IC_SET_W-1:0];
  endfunction

  function automatic line_t line_data(line_addr_t line);
    line_t data;
    for (int k = 0; k < `IC_LINE_WORDS; k++) begin
      data[k*`IC_ILEN +: `IC_ILEN] = word_at({line, {`IC_OFFSET_W{1'b0}}} + pc_t'(4 * k));
    end
    return data;
  endfunction

  function automatic bit is_known(line_addr_t line);
    foreach (known_q[k]) begin
      if (known_q[k] == line) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic mark_known(line_addr_t line);
    if (!is_known(line)) begin
      known_q.push_back(line);
    end
  endtask

  // A refill into a full set may have replaced any other line of it
  task automatic record_refill(line_addr_t line);
    set_idx_t   s;
    line_addr_t kept [$];
    s = set_of(line);
    if (filled[s] < `IC_NUM_WAYS) begin
      filled[s]++;
    end else begin
      foreach (known_q[k]) begin
        if (set_of(known_q[k]) != s || known_q[k] == line) begin
          kept.push_back(known_q[k]);
        end
      end
      known_q = kept;
    end
    mark_known(line);
  endtask

  // ----------------------------------------------------------------------
  // Checking and reporting
  // ----------------------------------------------------------------------
  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(string what);
    errors++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  task automatic print_summary();
    $display("Fetches %0d, responses %0d, memory requests %0d, checks %0d, errors %0d",
             accepted, responded, mem_reqs, checks, errors);
  endtask

  task automatic check_mem_request(line_addr_t line);
    mem_reqs++;
    if (!fetch_active) begin
      report_failure("Memory request with no fetch in flight");
    end else if (line != cur_line_a && !(cur_cross && line == cur_line_b)) begin
      report_failure($sformatf("Memory request for line %h not needed by pc %h", line, cur_pc));
    end else if (is_known(line)) begin
      report_failure($sformatf("Memory request for resident line %h", line));
    end
  endtask

  // ----------------------------------------------------------------------
  // Monitors sampled 1 ns after the falling edge
  // ----------------------------------------------------------------------
  task automatic monitor_request();
    if (req_valid_i && req_ready_o) begin
      accepted++;
      fetch_active = 1'b1;
      cur_pc       = req_i.pc;
      cur_line_a   = line_of(cur_pc);
      cur_line_b   = line_of(cur_pc + pc_t'(`IC_LINE_W / 8));
      // On the last slot of a line the second word comes from the next line
      cur_cross    = (cur_pc[3:2] == 2'b11);
      cur_known    = is_known(cur_line_a) && (!cur_cross || is_known(cur_line_b));
      accept_cyc   = cyc;
      rsp_seen     = 1'b0;
    end
  endtask

  task automatic monitor_response();
    if (rsp_valid_o && !rsp_seen && fetch_active) begin
      rsp_seen = 1'b1;
      // All lines resident so the fetch must be a plain hit
      if (cur_known) begin
        check_value("response latency", 64'(cyc - accept_cyc), 64'(HIT_LATENCY));
      end
    end
    if (rsp_valid_o && rsp_ready_i) begin
      if (!fetch_active) begin
        report_failure("Response with no fetch in flight");
      end else begin
        check_value("rsp_o.instrs[0]", 64'(rsp_o.instrs[0]), 64'(word_at(cur_pc)));
        check_value("rsp_o.instrs[1]", 64'(rsp_o.instrs[1]), 64'(word_at(cur_pc + 4)));
        mark_known(cur_line_a);
        if (cur_cross) begin
          mark_known(cur_line_b);
        end
        fetch_active = 1'b0;
        responded++;
      end
    end
  endtask

  // Memory answers each line after 0 to 5 cycles
  task automatic drive_memory();
    case (mem_state)
      MEM_IDLE: begin
        mem_rsp_valid_i = 1'b0;
      end
      MEM_DELAY: begin
        mem_req_ready_i = 1'b0;
        if (mem_delay == 0) begin
          mem_rsp_valid_i = 1'b1;
          mem_rsp_i.data  = line_data(mem_line);
          mem_state       = MEM_RESP;
        end else begin
          mem_delay--;
        end
      end
      default: begin
      end
    endcase
  endtask

  task automatic monitor_memory(logic [31:0] rnd);
    if (mem_state == MEM_IDLE && mem_req_valid_o && mem_req_ready_i) begin
      mem_line = mem_req_o.line_addr;
      check_mem_request(mem_line);
      mem_delay = int'(rnd[7:3]) % 6;
      mem_state = MEM_DELAY;
    end else if (mem_state == MEM_RESP && mem_rsp_valid_i && mem_rsp_ready_o) begin
      record_refill(mem_line);
      mem_state = MEM_IDLE;
    end
  endtask

  initial begin : environment
    logic [31:0] rnd;
    wait (rst_ni === 1'b1);
    forever begin
      @(negedge clk_i);
      cyc++;
      rnd = $random(seed);
      // Response ready three cycles out of four
      rsp_ready_i = rnd[0] | rnd[1];
      if (mem_state == MEM_IDLE) begin
        mem_req_ready_i = rnd[2];
      end
      drive_memory();
      #1;
      monitor_request();
      monitor_response();
      monitor_memory(rnd);
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  // Present one fetch and wait for its response
  task automatic send_fetch(pc_t pc, int idx);
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i.pc    = pc;
    while (accepted <= idx) begin
      @(negedge clk_i);
    end
    req_valid_i = 1'b0;
    while (responded <= idx) begin
      @(negedge clk_i);
    end
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_i           = '0;
    rsp_ready_i     = 1'b0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i       = '0;
    errors          = 0;
    checks          = 0;
    cyc             = 0;
    accepted        = 0;
    responded       = 0;
    mem_reqs        = 0;
    fetch_active    = 1'b0;
    rsp_seen        = 1'b0;
    mem_state       = MEM_IDLE;
    mem_delay       = 0;
    foreach (filled[s]) begin
      filled[s] = 0;
    end

    // Two lines of set 5 with different tags and each fetched twice
    pcs[0] = 32'h0000_0050;
    pcs[1] = 32'h0000_00d0;
    pcs[2] = pcs[0];
    pcs[3] = pcs[1];
    // Random PCs over 64 lines with immediate refetches and cross-line fetches
    for (int i = 4; i < NUM_REQ; i++) begin
      rnd = $random(seed);
      if (rnd[1:0] == 2'b00) begin
        pcs[i] = pcs[i-1];
      end else begin
        pcs[i] = 32'h0000_1000 | (pc_t'(rnd[9:2]) << 2);
        if (rnd[11:10] == 2'b00) begin
          pcs[i][3:2] = 2'b11;
        end
      end
    end

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Only the fetch request channel is ready out of reset
    check_value("req_ready_o", 64'(req_ready_o), 64'(1));
    check_value("rsp_valid_o", 64'(rsp_valid_o), 64'(0));
    check_value("mem_req_valid_o", 64'(mem_req_valid_o), 64'(0));
    check_value("mem_rsp_ready_o", 64'(mem_rsp_ready_o), 64'(0));

    for (int i = 0; i < NUM_REQ; i++) begin
      send_fetch(pcs[i], i);
    end
    // Idle cycles catch a stray response
    repeat (10) @(negedge clk_i);

    errors += dut_i.u_assert.fail_count;
    print_summary();
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(NUM_REQ * REQ_CYCLES * CLK_PERIOD);
    $display("Timeout: fetches did not complete within %0d cycles", NUM_REQ * REQ_CYCLES);
    print_summary();
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== test/icache_assert.sv ====
// Cache handshake assertions
`timescale 1ns/1ps

module icache_assert
  import icache_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input logic       req_ready_o,
  input logic       rsp_valid_o,
  input logic       rsp_ready_i,
  input fetch_rsp_t rsp_o,
  input logic       mem_req_valid_o,
  input logic       mem_req_ready_i,
  input mem_req_t   mem_req_o
);

  // Failed assertions, read by the testbench at the end
  int fail_count;

  // ----------------------------------------------------------------------
  // Channel stability
  // ----------------------------------------------------------------------
  // Memory request held until accepted
  a_mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
  else begin
    $error("Memory request dropped or changed before it was accepted");
    fail_count++;
  end

  // Response held until taken
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
  else begin
    $error("Fetch response dropped or changed before it was taken");
    fail_count++;
  end

  // ----------------------------------------------------------------------
  // Single fetch in flight
  // ----------------------------------------------------------------------
  a_no_req_while_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> !req_ready_o)
  else begin
    $error("Request accepted while a response is pending");
    fail_count++;
  end

endmodule

// ==== hw/icache_top.sv ====
// Instruction cache top level
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // Fetch request
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  fetch_req_t req_i,
  // Fetch response
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output fetch_rsp_t rsp_o,
  // Memory request
  output logic       mem_req_valid_o,
  input  logic       mem_req_ready_i,
  output mem_req_t   mem_req_o,
  // Refill
  input  logic       mem_rsp_valid_i,
  output logic       mem_rsp_ready_o,
  input  mem_rsp_t   mem_rsp_i
);

  // Array addressing and refill write
  set_idx_t                 rd_set_a;
  set_idx_t                 rd_set_b;
  set_idx_t                 wr_set;
  logic  [`IC_NUM_WAYS-1:0] wr_way_mask;
  tag_t                     wr_tag;
  line_t                    wr_line;
  // Array read data
  tag_t  [`IC_NUM_WAYS-1:0] tags_a;
  tag_t  [`IC_NUM_WAYS-1:0] tags_b;
  logic  [`IC_NUM_WAYS-1:0] valid_a;
  logic  [`IC_NUM_WAYS-1:0] valid_b;
  line_t [`IC_NUM_WAYS-1:0] lines_a;
  line_t [`IC_NUM_WAYS-1:0] lines_b;
  // Lookup results
  tag_t                     exp_tag_a;
  tag_t                     exp_tag_b;
  slot_t                    start_slot;
  logic                     cross_line;
  logic                     hit_a;
  logic                     hit_b;
  fetch_rsp_t               instrs;
  logic                     miss_on_b;
  way_idx_t                 victim_way;

  icache_ctrl u_ctrl (
    .clk_i,
    .rst_ni,
    .req_valid_i,
    .req_ready_o,
    .req_i,
    .rsp_valid_o,
    .rsp_ready_i,
    .rsp_o,
    .mem_req_valid_o,
    .mem_req_ready_i,
    .mem_req_o,
    .mem_rsp_valid_i,
    .mem_rsp_ready_o,
    .mem_rsp_i,
    .rd_set_a_o    (rd_set_a),
    .rd_set_b_o    (rd_set_b),
    .wr_set_o      (wr_set),
    .wr_way_mask_o (wr_way_mask),
    .wr_tag_o      (wr_tag),
    .wr_line_o     (wr_line),
    .exp_tag_a_o   (exp_tag_a),
    .exp_tag_b_o   (exp_tag_b),
    .start_slot_o  (start_slot),
    .cross_line_o  (cross_line),
    .hit_a_i       (hit_a),
    .hit_b_i       (hit_b),
    .instrs_i      (instrs),
    .victim_way_i  (victim_way),
    .miss_on_b_o   (miss_on_b)
  );

  icache_arrays u_arrays (
    .clk_i,
    .rst_ni,
    .rd_set_a_i    (rd_set_a),
    .rd_set_b_i    (rd_set_b),
    .wr_set_i      (wr_set),
    .wr_way_mask_i (wr_way_mask),
    .wr_tag_i      (wr_tag),
    .wr_line_i     (wr_line),
    .tags_a_o      (tags_a),
    .tags_b_o      (tags_b),
    .valid_a_o     (valid_a),
    .valid_b_o     (valid_b),
    .lines_a_o     (lines_a),
    .lines_b_o     (lines_b)
  );

  icache_fetch_align u_align (
    .tags_a_i      (tags_a),
    .tags_b_i      (tags_b),
    .valid_a_i     (valid_a),
    .valid_b_i     (valid_b),
    .lines_a_i     (lines_a),
    .lines_b_i     (lines_b),
    .exp_tag_a_i   (exp_tag_a),
    .exp_tag_b_i   (exp_tag_b),
    .start_slot_i  (start_slot),
    .cross_line_i  (cross_line),
    .hit_a_o       (hit_a),
    .hit_b_o       (hit_b),
    .instrs_o      (instrs)
  );

  icache_victim_sel u_victim (
    .clk_i,
    .rst_ni,
    .valid_a_i     (valid_a),
    .valid_b_i     (valid_b),
    .miss_on_b_i   (miss_on_b),
    .victim_way_o  (victim_way)
  );

endmodule

// ==== hw/icache_ctrl.sv ====
// Instruction cache controller
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Fetch request
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  fetch_req_t              req_i,
  // Fetch response
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output fetch_rsp_t              rsp_o,
  // Memory request
  output logic                    mem_req_valid_o,
  input  logic                    mem_req_ready_i,
  output mem_req_t                mem_req_o,
  // Refill
  input  logic                    mem_rsp_valid_i,
  output logic                    mem_rsp_ready_o,
  input  mem_rsp_t                mem_rsp_i,
  // Array control
  output set_idx_t                rd_set_a_o,
  output set_idx_t                rd_set_b_o,
  output set_idx_t                wr_set_o,
  output logic [`IC_NUM_WAYS-1:0] wr_way_mask_o,
  output tag_t                    wr_tag_o,
  output line_t                   wr_line_o,
  // Aligner and victim selector
  output tag_t                    exp_tag_a_o,
  output tag_t                    exp_tag_b_o,
  output slot_t                   start_slot_o,
  output logic                    cross_line_o,
  input  logic                    hit_a_i,
  input  logic                    hit_b_i,
  input  fetch_rsp_t              instrs_i,
  input  way_idx_t                victim_way_i,
  output logic                    miss_on_b_o
);

  ic_state_e  state_q;
  ic_state_e  state_d;
  logic       accept;
  logic       hit_all;
  // PC decode of the incoming request
  line_addr_t req_line_a;
  line_addr_t req_line_b;
  slot_t      req_slot;
  logic       req_cross;
  // Request context
  line_addr_t line_a_q;
  line_addr_t line_b;
  slot_t      start_slot_q;
  logic       cross_line_q;
  // Miss context
  line_addr_t miss_line_q;
  way_idx_t   miss_way_q;
  // Output registers
  logic       rsp_valid_q;
  fetch_rsp_t rsp_q;
  logic       mem_req_valid_q;

  function automatic set_idx_t set_of(line_addr_t line);
    return line[`IC_SET_W-1:0];
  endfunction

  function automatic tag_t tag_of(line_addr_t line);
    return line[`IC_LINE_ADDR_W-1:`IC_SET_W];
  endfunction

  // ----------------------------------------------------------------------
  // PC decode and read addressing
  // ----------------------------------------------------------------------
  assign req_line_a = req_i.pc[`IC_PLEN-1:`IC_OFFSET_W];
  assign req_line_b = req_line_a + 1'b1;
  assign req_slot   = req_i.pc[`IC_OFFSET_W-1 -: `IC_SLOT_W];
  // Fetch runs past the end of line A
  assign req_cross  = int'(req_slot) > (`IC_LINE_WORDS - `IC_FETCH_NUM);

  assign req_ready_o = (state_q == IDLE) && !rsp_valid_q;
  assign accept      = req_valid_i && req_ready_o;

  // Decoded sets go straight to the arrays in the accept cycle
  assign line_b     = line_a_q + 1'b1;
  assign rd_set_a_o = accept ? set_of(req_line_a) : set_of(line_a_q);
  assign rd_set_b_o = accept ? set_of(req_line_b) : set_of(line_b);

  assign exp_tag_a_o  = tag_of(line_a_q);
  assign exp_tag_b_o  = tag_of(line_b);
  assign start_slot_o = start_slot_q;
  assign cross_line_o = cross_line_q;

  // Line A hit on a cross-line fetch, so line B missed
  assign miss_on_b_o = hit_a_i && cross_line_q;
  assign hit_all     = hit_a_i && (!cross_line_q || hit_b_i);

  // ----------------------------------------------------------------------
  // Channel outputs and refill write
  // ----------------------------------------------------------------------
  assign rsp_valid_o         = rsp_valid_q;
  assign rsp_o               = rsp_q;
  assign mem_req_valid_o     = mem_req_valid_q;
  assign mem_req_o.line_addr = miss_line_q;
  assign mem_rsp_ready_o     = (state_q == MISS_WAIT);

  assign wr_set_o  = set_of(miss_line_q);
  assign wr_tag_o  = tag_of(miss_line_q);
  assign wr_line_o = mem_rsp_i.data;

  always_comb begin
    wr_way_mask_o             = '0;
    wr_way_mask_o[miss_way_q] = (state_q == MISS_WAIT) && mem_rsp_valid_i;
  end

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (accept) state_d = LOOKUP;
      LOOKUP:    state_d = hit_all ? IDLE : MISS_REQ;
      MISS_REQ:  if (mem_req_valid_q && mem_req_ready_i) state_d = MISS_WAIT;
      // Lookup again once the line is written
      MISS_WAIT: if (mem_rsp_valid_i) state_d = LOOKUP;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= IDLE;
      rsp_valid_q     <= 1'b0;
      mem_req_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Response held until taken
      if (state_q == LOOKUP && hit_all) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      // Memory request raised one cycle into MISS_REQ
      if (state_q == MISS_REQ && !mem_req_valid_q) begin
        mem_req_valid_q <= 1'b1;
      end else if (mem_req_ready_i) begin
        mem_req_valid_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Request, miss and response payload
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      line_a_q     <= req_line_a;
      start_slot_q <= req_slot;
      cross_line_q <= req_cross;
    end
    if (state_q == LOOKUP) begin
      if (hit_all) begin
        rsp_q <= instrs_i;
      end else begin
        miss_line_q <= miss_on_b_o ? line_b : line_a_q;
        miss_way_q  <= victim_way_i;
      end
    end
  end

endmodule

// ==== hw/icache_fetch_align.sv ====
// Hit check and fetch assembly
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_fetch_align
  import icache_pkg::*;
(
  input  tag_t  [`IC_NUM_WAYS-1:0] tags_a_i,
  input  tag_t  [`IC_NUM_WAYS-1:0] tags_b_i,
  input  logic  [`IC_NUM_WAYS-1:0] valid_a_i,
  input  logic  [`IC_NUM_WAYS-1:0] valid_b_i,
  input  line_t [`IC_NUM_WAYS-1:0] lines_a_i,
  input  line_t [`IC_NUM_WAYS-1:0] lines_b_i,
  input  tag_t                     exp_tag_a_i,
  input  tag_t                     exp_tag_b_i,
  input  slot_t                    start_slot_i,
  input  logic                     cross_line_i,
  output logic                     hit_a_o,
  output logic                     hit_b_o,
  output fetch_rsp_t               instrs_o
);

  way_idx_t                    way_a;
  way_idx_t                    way_b;
  instr_t [`IC_LINE_WORDS-1:0] words_a;
  instr_t [`IC_LINE_WORDS-1:0] words_b;

  // ----------------------------------------------------------------------
  // Tag compare
  // ----------------------------------------------------------------------
  // Lowest hitting way wins on each port
  always_comb begin
    hit_a_o = 1'b0;
    hit_b_o = 1'b0;
    way_a   = '0;
    way_b   = '0;
    for (int w = `IC_NUM_WAYS - 1; w >= 0; w--) begin
      if (valid_a_i[w] && (tags_a_i[w] == exp_tag_a_i)) begin
        hit_a_o = 1'b1;
        way_a   = way_idx_t'(w);
      end
      if (valid_b_i[w] && (tags_b_i[w] == exp_tag_b_i)) begin
        hit_b_o = 1'b1;
        way_b   = way_idx_t'(w);
      end
    end
  end

  // Hitting lines split into instruction words
  assign words_a = lines_a_i[way_a];
  assign words_b = lines_b_i[way_b];

  // ----------------------------------------------------------------------
  // Instruction assembly
  // ----------------------------------------------------------------------
  always_comb begin
    slot_t slot;
    instrs_o = '0;
    for (int i = 0; i < `IC_FETCH_NUM; i++) begin
      // Slot index wraps into line B
      slot = start_slot_i + slot_t'(i);
      if (cross_line_i && (int'(start_slot_i) + i >= `IC_LINE_WORDS)) begin
        instrs_o.instrs[i] = words_b[slot];
      end else begin
        instrs_o.instrs[i] = words_a[slot];
      end
    end
  end

endmodule

// ==== hw/icache_victim_sel.sv ====
// Refill way selection
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_victim_sel
  import icache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`IC_NUM_WAYS-1:0] valid_a_i,
  input  logic [`IC_NUM_WAYS-1:0] valid_b_i,
  input  logic                    miss_on_b_i,
  output way_idx_t                victim_way_o
);

  logic [3:0]              lfsr_q;
  logic [`IC_NUM_WAYS-1:0] valid_sel;

  // ----------------------------------------------------------------------
  // Free-running LFSR
  // ----------------------------------------------------------------------
  // Polynomial x^4 + x^3 + 1, period 15
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 4'h1;
    end else begin
      lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
    end
  end

  // ----------------------------------------------------------------------
  // Victim choice
  // ----------------------------------------------------------------------
  // Valid bits of the set that missed
  assign valid_sel = miss_on_b_i ? valid_b_i : valid_a_i;

  always_comb begin
    // Random way when the set is full
    victim_way_o = lfsr_q[`IC_WAY_W-1:0];
    // Downward scan so the lowest invalid way wins
    for (int w = `IC_NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_sel[w]) begin
        victim_way_o = way_idx_t'(w);
      end
    end
  end

endmodule

// ==== hw/icache_arrays.sv ====
// Cache tag and data arrays
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_arrays
  import icache_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  set_idx_t                     rd_set_a_i,
  input  set_idx_t                     rd_set_b_i,
  input  set_idx_t                     wr_set_i,
  input  logic  [`IC_NUM_WAYS-1:0]     wr_way_mask_i,
  input  tag_t                         wr_tag_i,
  input  line_t                        wr_line_i,
  output tag_t  [`IC_NUM_WAYS-1:0]     tags_a_o,
  output tag_t  [`IC_NUM_WAYS-1:0]     tags_b_o,
  output logic  [`IC_NUM_WAYS-1:0]     valid_a_o,
  output logic  [`IC_NUM_WAYS-1:0]     valid_b_o,
  output line_t [`IC_NUM_WAYS-1:0]     lines_a_o,
  output line_t [`IC_NUM_WAYS-1:0]     lines_b_o
);

  // Storage per way and set
  tag_t                    tag_mem  [`IC_NUM_WAYS][`IC_NUM_SETS];
  line_t                   data_mem [`IC_NUM_WAYS][`IC_NUM_SETS];
  logic [`IC_NUM_SETS-1:0] valid_q  [`IC_NUM_WAYS];

  // Read ports, entry 0 is port A and entry 1 is port B
  set_idx_t                 rd_set     [2];
  logic  [`IC_NUM_WAYS-1:0] byp        [2];
  tag_t  [`IC_NUM_WAYS-1:0] rd_tags_q  [2];
  logic  [`IC_NUM_WAYS-1:0] rd_valid_q [2];
  line_t [`IC_NUM_WAYS-1:0] rd_lines_q [2];

  assign rd_set[0] = rd_set_a_i;
  assign rd_set[1] = rd_set_b_i;

  assign tags_a_o  = rd_tags_q[0];
  assign tags_b_o  = rd_tags_q[1];
  assign valid_a_o = rd_valid_q[0];
  assign valid_b_o = rd_valid_q[1];
  assign lines_a_o = rd_lines_q[0];
  assign lines_b_o = rd_lines_q[1];

  // ----------------------------------------------------------------------
  // Refill write port
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `IC_NUM_WAYS; w++) begin
      if (wr_way_mask_i[w]) begin
        tag_mem[w][wr_set_i]  <= wr_tag_i;
        data_mem[w][wr_set_i] <= wr_line_i;
      end
    end
  end

  // Valid bits start cleared, a refill marks its way
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else begin
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
        if (wr_way_mask_i[w]) begin
          valid_q[w][wr_set_i] <= 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Registered read ports
  // ----------------------------------------------------------------------
  // A write to the set being read is returned on the same edge
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      byp[p] = wr_way_mask_i & {`IC_NUM_WAYS{wr_set_i == rd_set[p]}};
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_port
    always_ff @(posedge clk_i) begin
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
        rd_tags_q[p][w]  <= byp[p][w] ? wr_tag_i : tag_mem[w][rd_set[p]];
        rd_lines_q[p][w] <= byp[p][w] ? wr_line_i : data_mem[w][rd_set[p]];
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rd_valid_q[p] <= '0;
      end else begin
        for (int w = 0; w < `IC_NUM_WAYS; w++) begin
          rd_valid_q[p][w] <= byp[p][w] | valid_q[w][rd_set[p]];
        end
      end
    end
  end

endmodule

// ==== hw/icache_pkg.sv ====
// Instruction cache types
`include "icache_consts.svh"

package icache_pkg;

  // ----------------------------------------------------------------------
  // Address and data widths
  // ----------------------------------------------------------------------
  typedef logic [`IC_PLEN-1:0]        pc_t;
  // PC without the line offset
  typedef logic [`IC_LINE_ADDR_W-1:0] line_addr_t;
  typedef logic [`IC_SET_W-1:0]       set_idx_t;
  typedef logic [`IC_TAG_W-1:0]       tag_t;
  typedef logic [`IC_WAY_W-1:0]       way_idx_t;
  // Instruction position inside a line
  typedef logic [`IC_SLOT_W-1:0]      slot_t;
  typedef logic [`IC_ILEN-1:0]        instr_t;
  typedef logic [`IC_LINE_W-1:0]      line_t;

  // ----------------------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    pc_t pc;
  } fetch_req_t;

  // Entry 0 is the instruction at pc
  typedef struct packed {
    instr_t [`IC_FETCH_NUM-1:0] instrs;
  } fetch_rsp_t;

  typedef struct packed {
    line_addr_t line_addr;
  } mem_req_t;

  typedef struct packed {
    line_t data;
  } mem_rsp_t;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    MISS_REQ,
    MISS_WAIT
  } ic_state_e;

endpackage

// ==== hw/icache_consts.svh ====
// Instruction cache geometry
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// ----------------------------------------------------------------------
// Base geometry
// ----------------------------------------------------------------------
// Ways per set
`define IC_NUM_WAYS    2
// Sets in each way
`define IC_NUM_SETS    8
// Instructions per line
`define IC_LINE_WORDS  4
// Instruction width in bits
`define IC_ILEN        32
// Instructions returned by one fetch
`define IC_FETCH_NUM   2
// Physical address width
`define IC_PLEN        32

// ----------------------------------------------------------------------
// Derived widths
// ----------------------------------------------------------------------
`define IC_WAY_W       $clog2(`IC_NUM_WAYS)
`define IC_SET_W       $clog2(`IC_NUM_SETS)
`define IC_SLOT_W      $clog2(`IC_LINE_WORDS)
`define IC_LINE_W      (`IC_LINE_WORDS * `IC_ILEN)
// Byte offset bits inside a line
`define IC_OFFSET_W    $clog2(`IC_LINE_W / 8)
`define IC_LINE_ADDR_W (`IC_PLEN - `IC_OFFSET_W)
`define IC_TAG_W       (`IC_LINE_ADDR_W - `IC_SET_W)

`endif
